//--- common/fetch_unit_pkg.sv
`default_nettype none

package fetch_unit_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [15:0] offset_t;

    // Physical address bits 19 to 1
    typedef logic [18:0] word_addr_t;

    localparam int FIFO_DEPTH    = 6;
    localparam int FIFO_MIN_FREE = 2;

    typedef logic [2:0] fifo_count_t;

    localparam offset_t RESET_CS = 16'hffff;
    localparam offset_t RESET_IP = 16'h0000;

    typedef enum logic [1:0] {
        PF_IDLE,
        PF_WAIT_ACK,
        PF_PUSH_LOW,
        PF_PUSH_HIGH
    } prefetch_state_t;

    typedef enum logic [1:0] {
        IMM_IDLE,
        IMM_READ_LOW,
        IMM_READ_HIGH,
        IMM_DONE
    } immed_state_t;

endpackage

`default_nettype wire

//--- fetch_unit.f
common/fetch_unit_pkg.sv
src/byte_fifo.sv
prefetch/prefetch.sv
src/immediate_reader.sv
src/fetch_unit.sv
tb/instr_bus_responder.sv
tb/fetch_unit_tb.sv

//--- prefetch/prefetch.sv
`timescale 1ns/10ps
`default_nettype none

module prefetch (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       load_new_ip,
    input  fetch_unit_pkg::offset_t    new_cs,
    input  fetch_unit_pkg::offset_t    new_ip,
    input  logic                       fifo_nearly_full,
    input  logic                       mem_ack,
    input  fetch_unit_pkg::word_t      mem_data,
    output logic                       fifo_wr_en,
    output fetch_unit_pkg::byte_t      fifo_wr_data,
    output logic                       mem_access,
    output fetch_unit_pkg::word_addr_t mem_address
);

    fetch_unit_pkg::prefetch_state_t state;
    fetch_unit_pkg::offset_t         cs;
    fetch_unit_pkg::offset_t         fetch_ip;
    fetch_unit_pkg::word_t           fetched_word;
    logic                            stale;
    logic [19:0]                     phys_addr;

    // Segment times 16 plus offset modulo 1M
    assign phys_addr = {cs, 4'b0000} + {4'b0000, fetch_ip};

    assign mem_access   = (state == fetch_unit_pkg::PF_WAIT_ACK);
    assign fifo_wr_en   = (state == fetch_unit_pkg::PF_PUSH_LOW) ||
                          (state == fetch_unit_pkg::PF_PUSH_HIGH);
    assign fifo_wr_data = (state == fetch_unit_pkg::PF_PUSH_LOW) ? fetched_word[7:0] :
                                                                   fetched_word[15:8];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= fetch_unit_pkg::PF_IDLE;
            cs          <= fetch_unit_pkg::RESET_CS;
            fetch_ip    <= fetch_unit_pkg::RESET_IP;
            stale       <= 1'b0;
            mem_address <= '0;
        end else begin
            if (load_new_ip) begin
                cs       <= new_cs;
                fetch_ip <= new_ip;
            end else if (fifo_wr_en) begin
                fetch_ip <= fetch_ip + 16'd1;
            end

            case (state)
                fetch_unit_pkg::PF_IDLE: begin
                    if (!load_new_ip && !fifo_nearly_full) begin
                        // Address is held for the whole access
                        mem_address <= phys_addr[19:1];
                        state       <= fetch_unit_pkg::PF_WAIT_ACK;
                    end
                end
                fetch_unit_pkg::PF_WAIT_ACK: begin
                    if (mem_ack) begin
                        stale <= 1'b0;
                        if (stale || load_new_ip)
                            state <= fetch_unit_pkg::PF_IDLE;
                        else if (fetch_ip[0])
                            state <= fetch_unit_pkg::PF_PUSH_HIGH;
                        else
                            state <= fetch_unit_pkg::PF_PUSH_LOW;
                    end else if (load_new_ip) begin
                        // Word in flight belongs to the old stream
                        stale <= 1'b1;
                    end
                end
                fetch_unit_pkg::PF_PUSH_LOW: begin
                    if (load_new_ip)
                        state <= fetch_unit_pkg::PF_IDLE;
                    else
                        state <= fetch_unit_pkg::PF_PUSH_HIGH;
                end
                fetch_unit_pkg::PF_PUSH_HIGH: begin
                    state <= fetch_unit_pkg::PF_IDLE;
                end
                default: begin
                    state <= fetch_unit_pkg::PF_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mem_access && mem_ack)
            fetched_word <= mem_data;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/10ps -j 0 --top-module fetch_unit_tb -f fetch_unit.f

out=$(./obj_dir/Vfetch_unit_tb)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TEST PASS"

//--- src/byte_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module byte_fifo (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  wr_en,
    input  fetch_unit_pkg::byte_t wr_data,
    input  logic                  rd_en,
    output fetch_unit_pkg::byte_t rd_data,
    output logic                  empty,
    output logic                  nearly_full
);

    fetch_unit_pkg::byte_t       mem [fetch_unit_pkg::FIFO_DEPTH];
    fetch_unit_pkg::fifo_count_t wr_ptr;
    fetch_unit_pkg::fifo_count_t rd_ptr;
    fetch_unit_pkg::fifo_count_t count;
    logic                        full;
    logic                        do_wr;
    logic                        do_rd;

    function automatic fetch_unit_pkg::fifo_count_t next_ptr(fetch_unit_pkg::fifo_count_t p);
        if (p == fetch_unit_pkg::fifo_count_t'(fetch_unit_pkg::FIFO_DEPTH - 1))
            return '0;
        return p + 3'd1;
    endfunction

    assign full        = (count == fetch_unit_pkg::fifo_count_t'(fetch_unit_pkg::FIFO_DEPTH));
    assign empty       = (count == '0);
    assign nearly_full = (count > fetch_unit_pkg::fifo_count_t'(fetch_unit_pkg::FIFO_DEPTH -
                                                                fetch_unit_pkg::FIFO_MIN_FREE));

    // Flush wins over both ports
    assign do_wr = wr_en & ~full & ~flush;
    assign do_rd = rd_en & ~empty & ~flush;

    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_rd)
                rd_ptr <= next_ptr(rd_ptr);
            if (do_wr && !do_rd)
                count <= count + 3'd1;
            else if (do_rd && !do_wr)
                count <= count - 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

endmodule

`default_nettype wire

//--- src/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       load_new_ip,
    input  fetch_unit_pkg::offset_t    new_cs,
    input  fetch_unit_pkg::offset_t    new_ip,
    input  logic                       instr_m_ack,
    input  fetch_unit_pkg::word_t      instr_m_data_in,
    input  logic                       immed_start,
    input  logic                       immed_is_8bit,
    output fetch_unit_pkg::word_addr_t instr_m_addr,
    output logic                       instr_m_access,
    output logic                       immed_busy,
    output logic                       immed_complete,
    output fetch_unit_pkg::word_t      immediate,
    output fetch_unit_pkg::offset_t    ip_current
);

    logic                  fifo_flush;
    logic                  fifo_wr_en;
    fetch_unit_pkg::byte_t fifo_wr_data;
    logic                  fifo_rd_en;
    fetch_unit_pkg::byte_t fifo_rd_data;
    logic                  fifo_empty;
    logic                  fifo_nearly_full;
    logic                  immed_fifo_rd_en;
    logic                  ip_inc;

    // Redirect empties the queue on the same edge
    assign fifo_flush = load_new_ip;

    // Immediate reader is the only queue consumer
    assign fifo_rd_en = immed_fifo_rd_en;
    assign ip_inc     = fifo_rd_en & ~fifo_empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ip_current <= fetch_unit_pkg::RESET_IP;
        else if (load_new_ip)
            ip_current <= new_ip;
        else if (ip_inc)
            ip_current <= ip_current + 16'd1;
    end

    byte_fifo byte_fifo_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (fifo_flush),
        .wr_en       (fifo_wr_en),
        .wr_data     (fifo_wr_data),
        .rd_en       (fifo_rd_en),
        .rd_data     (fifo_rd_data),
        .empty       (fifo_empty),
        .nearly_full (fifo_nearly_full)
    );

    prefetch prefetch_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .load_new_ip      (load_new_ip),
        .new_cs           (new_cs),
        .new_ip           (new_ip),
        .fifo_nearly_full (fifo_nearly_full),
        .mem_ack          (instr_m_ack),
        .mem_data         (instr_m_data_in),
        .fifo_wr_en       (fifo_wr_en),
        .fifo_wr_data     (fifo_wr_data),
        .mem_access       (instr_m_access),
        .mem_address      (instr_m_addr)
    );

    immediate_reader immediate_reader_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (immed_start),
        .is_8bit      (immed_is_8bit),
        .fifo_rd_data (fifo_rd_data),
        .fifo_empty   (fifo_empty),
        .busy         (immed_busy),
        .complete     (immed_complete),
        .immediate    (immediate),
        .fifo_rd_en   (immed_fifo_rd_en)
    );

endmodule

`default_nettype wire

//--- src/immediate_reader.sv
`timescale 1ns/10ps
`default_nettype none

module immediate_reader (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  is_8bit,
    input  fetch_unit_pkg::byte_t fifo_rd_data,
    input  logic                  fifo_empty,
    output logic                  busy,
    output logic                  complete,
    output fetch_unit_pkg::word_t immediate,
    output logic                  fifo_rd_en
);

    fetch_unit_pkg::immed_state_t state;
    logic                         single_byte;
    logic                         reading;

    assign reading    = (state == fetch_unit_pkg::IMM_READ_LOW) ||
                        (state == fetch_unit_pkg::IMM_READ_HIGH);
    assign busy       = reading;
    assign complete   = (state == fetch_unit_pkg::IMM_DONE);
    assign fifo_rd_en = reading & ~fifo_empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= fetch_unit_pkg::IMM_IDLE;
        end else begin
            case (state)
                fetch_unit_pkg::IMM_READ_LOW: begin
                    if (!fifo_empty)
                        state <= single_byte ? fetch_unit_pkg::IMM_DONE :
                                               fetch_unit_pkg::IMM_READ_HIGH;
                end
                fetch_unit_pkg::IMM_READ_HIGH: begin
                    if (!fifo_empty)
                        state <= fetch_unit_pkg::IMM_DONE;
                end
                default: begin
                    // A new start may arrive in idle or in done
                    if (start)
                        state <= fetch_unit_pkg::IMM_READ_LOW;
                    else
                        state <= fetch_unit_pkg::IMM_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reading && start) begin
            single_byte <= is_8bit;
            immediate   <= '0;
        end else if (fifo_rd_en) begin
            if (state == fetch_unit_pkg::IMM_READ_LOW)
                immediate[7:0] <= fifo_rd_data;
            else
                immediate[15:8] <= fifo_rd_data;
        end
    end

endmodule

`default_nettype wire

//--- tb/fetch_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit_tb;

    localparam int NUM_OPS     = 300;
    localparam int CYCLE_LIMIT = NUM_OPS * 40;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       load_new_ip;
    fetch_unit_pkg::offset_t    new_cs;
    fetch_unit_pkg::offset_t    new_ip;
    logic                       instr_m_ack;
    fetch_unit_pkg::word_t      instr_m_data_in;
    logic                       immed_start;
    logic                       immed_is_8bit;
    fetch_unit_pkg::word_addr_t instr_m_addr;
    logic                       instr_m_access;
    logic                       immed_busy;
    logic                       immed_complete;
    fetch_unit_pkg::word_t      immediate;
    fetch_unit_pkg::offset_t    ip_current;

    fetch_unit_pkg::offset_t    exp_cs;
    fetch_unit_pkg::offset_t    exp_ip;
    int                         checks = 0;
    int                         errors = 0;
    int                         bus_errors = 0;
    int                         cycles = 0;
    logic                       prev_access = 1'b0;
    logic                       prev_ack = 1'b0;
    fetch_unit_pkg::word_addr_t prev_addr = '0;

    always #50 clk = ~clk;

    fetch_unit fetch_unit_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .load_new_ip     (load_new_ip),
        .new_cs          (new_cs),
        .new_ip          (new_ip),
        .instr_m_ack     (instr_m_ack),
        .instr_m_data_in (instr_m_data_in),
        .immed_start     (immed_start),
        .immed_is_8bit   (immed_is_8bit),
        .instr_m_addr    (instr_m_addr),
        .instr_m_access  (instr_m_access),
        .immed_busy      (immed_busy),
        .immed_complete  (immed_complete),
        .immediate       (immediate),
        .ip_current      (ip_current)
    );

    instr_bus_responder bus_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .access (instr_m_access),
        .addr   (instr_m_addr),
        .ack    (instr_m_ack),
        .data   (instr_m_data_in)
    );

    // Same contents as the responder memory
    function automatic fetch_unit_pkg::word_t word_at(fetch_unit_pkg::word_addr_t a);
        return (a[15:0] * 16'h6b3d) ^ {a[18:16], a[12:0]} ^ 16'h5a5a;
    endfunction

    function automatic fetch_unit_pkg::byte_t model_byte(fetch_unit_pkg::offset_t cs,
                                                         fetch_unit_pkg::offset_t ip);
        logic [19:0]           phys;
        fetch_unit_pkg::word_t w;
        phys = {cs, 4'h0} + {4'h0, ip};
        w    = word_at(phys[19:1]);
        return phys[0] ? w[15:8] : w[7:0];
    endfunction

    task automatic read_immediate(input logic is_8bit);
        fetch_unit_pkg::word_t expected;
        expected[7:0]  = model_byte(exp_cs, exp_ip);
        expected[15:8] = is_8bit ? 8'h00 : model_byte(exp_cs, exp_ip + 16'd1);
        @(posedge clk);
        immed_start   <= 1'b1;
        immed_is_8bit <= is_8bit;
        @(posedge clk);
        immed_start <= 1'b0;
        @(negedge clk);
        // Busy rises on the edge that takes start
        checks++;
        if (immed_busy !== 1'b1) begin
            errors++;
            $display("ERR immed_busy expected 1 actual %h", immed_busy);
        end
        while (!immed_complete)
            @(negedge clk);
        exp_ip = exp_ip + (is_8bit ? 16'd1 : 16'd2);
        checks += 3;
        if (immed_busy !== 1'b0) begin
            errors++;
            $display("ERR immed_busy expected 0 actual %h", immed_busy);
        end
        if (immediate !== expected) begin
            errors++;
            $display("ERR immediate expected %h actual %h", expected, immediate);
        end
        if (ip_current !== exp_ip) begin
            errors++;
            $display("ERR ip_current expected %h actual %h", exp_ip, ip_current);
        end
    endtask

    task automatic redirect(input fetch_unit_pkg::offset_t cs, input fetch_unit_pkg::offset_t ip);
        @(posedge clk);
        load_new_ip <= 1'b1;
        new_cs      <= cs;
        new_ip      <= ip;
        @(posedge clk);
        load_new_ip <= 1'b0;
        @(negedge clk);
        exp_cs = cs;
        exp_ip = ip;
        checks++;
        if (ip_current !== ip) begin
            errors++;
            $display("ERR ip_current expected %h actual %h", ip, ip_current);
        end
    endtask

    // Address must hold while an access waits for ack
    always @(negedge clk) begin
        if (rst_n && prev_access && !prev_ack) begin
            if (!instr_m_access) begin
                bus_errors++;
                $display("Bus error: instr_m_access fell before instr_m_ack at %0t", $time);
            end else if (instr_m_addr !== prev_addr) begin
                bus_errors++;
                $display("ERR instr_m_addr expected %h actual %h", prev_addr, instr_m_addr);
            end
        end
        prev_access = instr_m_access;
        prev_ack    = instr_m_ack;
        prev_addr   = instr_m_addr;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: no immed_complete pulse within %0d cycles, the fetch unit hangs",
                     CYCLE_LIMIT);
            $display("checks %0d, errors %0d, bus errors %0d", checks, errors, bus_errors);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        int   kind;
        logic wrap;
        void'($urandom(32'h1c0b_aeeb));
        rst_n         = 1'b0;
        load_new_ip   = 1'b0;
        new_cs        = '0;
        new_ip        = '0;
        immed_start   = 1'b0;
        immed_is_8bit = 1'b0;
        exp_cs        = fetch_unit_pkg::RESET_CS;
        exp_ip        = fetch_unit_pkg::RESET_IP;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checks += 2;
        if ({instr_m_access, immed_busy, immed_complete} !== 3'b000) begin
            errors++;
            $display("ERR {instr_m_access,immed_busy,immed_complete} expected 0 actual %h",
                     {instr_m_access, immed_busy, immed_complete});
        end
        if (ip_current !== fetch_unit_pkg::RESET_IP) begin
            errors++;
            $display("ERR ip_current expected %h actual %h", fetch_unit_pkg::RESET_IP, ip_current);
        end

        // Queue fills and fetching stalls
        redirect(16'($urandom), 16'($urandom));
        for (int i = 1; i <= 40; i++) begin
            @(negedge clk);
            if (i > 20) begin
                checks++;
                if (instr_m_access !== 1'b0) begin
                    errors++;
                    $display("ERR instr_m_access expected 0 actual %h", instr_m_access);
                end
            end
        end
        repeat (6) read_immediate(1'b1);

        for (int op = 0; op < NUM_OPS; op++) begin
            kind = $urandom_range(9, 0);
            if (kind < 4) begin
                read_immediate(1'b1);
            end else if (kind < 7) begin
                read_immediate(1'b0);
            end else if (kind < 8) begin
                // Near the top of memory so reads wrap at 1M
                wrap = ($urandom_range(3, 0) == 0);
                for (int i = 0; i < 6 && !instr_m_access; i++)
                    @(negedge clk);
                redirect(wrap ? 16'hffff : 16'($urandom),
                         wrap ? 16'($urandom_range(15, 8)) : 16'($urandom));
            end else begin
                repeat ($urandom_range(20, 1)) @(negedge clk);
            end
        end

        $display("checks %0d, errors %0d, bus errors %0d", checks, errors, bus_errors);
        if (errors + bus_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/instr_bus_responder.sv
`timescale 1ns/10ps
`default_nettype none

module instr_bus_responder (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       access,
    input  fetch_unit_pkg::word_addr_t addr,
    output logic                       ack,
    output fetch_unit_pkg::word_t      data
);

    logic [1:0] wait_len;
    logic [1:0] waited;

    // Memory contents are a fixed mix of the word address
    function automatic fetch_unit_pkg::word_t word_at(fetch_unit_pkg::word_addr_t a);
        return (a[15:0] * 16'h6b3d) ^ {a[18:16], a[12:0]} ^ 16'h5a5a;
    endfunction

    // Ack arrives after wait_len cycles of access
    assign ack  = access && (waited == wait_len);
    assign data = word_at(addr);

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            waited   <= '0;
            wait_len <= '0;
        end else if (ack) begin
            waited   <= '0;
            // Delay for the next access
            wait_len <= 2'($urandom_range(3, 0));
        end else if (access) begin
            waited <= waited + 2'd1;
        end
    end

endmodule

`default_nettype wire
